// File: dv/cpu_checker.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_checker (
    input  logic              clk,
    input  logic              cpu_en,
    input  cpu_pkg::spm_req_t test_spm_req,
    input  cpu_pkg::word_t    test_spm_rd_data,
    output int                check_count,
    output int                error_count
);

    localparam int IDX_W     = $clog2(`SPM_DEPTH);
    localparam int MAX_STEPS = 4096;
    localparam cpu_pkg::word_t HALT_INSN = {`OP_BEQ, 5'd0, 5'd0, 16'hffff};

    cpu_pkg::word_t img [`SPM_DEPTH];  // expected memory image
    bit             known [`SPM_DEPTH];
    cpu_pkg::word_t gpr [32];
    logic           cpu_en_q = 1'b0;
    int             checks = 0;
    int             errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    function automatic logic [IDX_W-1:0] word_index(input cpu_pkg::word_addr_t addr);
        return addr[IDX_W-1:0];
    endfunction

    // instruction-set model with one delay slot per branch
    task automatic run_model();
        cpu_pkg::word_addr_t      pc;
        cpu_pkg::word_addr_t      npc;
        cpu_pkg::word_addr_t      tgt;
        cpu_pkg::word_t           insn;
        cpu_pkg::word_t           a;
        cpu_pkg::word_t           b;
        cpu_pkg::word_t           imm;
        cpu_pkg::word_t           ea;
        cpu_pkg::word_t           res;
        logic [`OPCODE_WIDTH-1:0] op;
        logic                     wr;
        logic                     rtype;
        int                       steps;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        pc = '0;
        npc = cpu_pkg::word_addr_t'(1);
        steps = 0;
        insn = img[word_index(pc)];
        while (insn != HALT_INSN && steps < MAX_STEPS) begin
            op = insn[`INSN_OP_BITS];
            rtype = op inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR};
            a = gpr[insn[`INSN_RS_BITS]];
            b = rtype ? gpr[insn[`INSN_RT_BITS]] : gpr[insn[`INSN_RD_BITS]];
            imm = {{16{insn[15]}}, insn[`INSN_IMM_BITS]};
            ea = a + imm;
            res = '0;
            wr = rtype || op == `OP_ADDI;
            tgt = npc + cpu_pkg::word_addr_t'(1);
            case (op)
                `OP_ADD:  res = a + b;
                `OP_SUB:  res = a - b;
                `OP_AND:  res = a & b;
                `OP_OR:   res = a | b;
                `OP_XOR:  res = a ^ b;
                `OP_ADDI: res = a + imm;
                `OP_LOAD: begin
                    wr = ea[1:0] == 2'b00;  // misaligned load writes nothing
                    res = img[word_index(ea[31:2])];
                end
                `OP_STORE: begin
                    if (ea[1:0] == 2'b00) begin
                        img[word_index(ea[31:2])] = b;
                        known[word_index(ea[31:2])] = 1'b1;
                    end
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        tgt = pc + cpu_pkg::word_addr_t'(1) + imm[`WORD_ADDR_WIDTH-1:0];
                    end
                end
                default: ;
            endcase
            if (wr && insn[`INSN_RD_BITS] != '0) begin
                gpr[insn[`INSN_RD_BITS]] = res;
            end
            pc = npc;
            npc = tgt;
            steps++;
            insn = img[word_index(pc)];
        end
        if (steps >= MAX_STEPS) begin
            $display("Error: instruction model never reached the halt loop");
            errors++;
        end
    endtask

    task automatic compare_read(input cpu_pkg::word_addr_t addr, input cpu_pkg::word_t actual);
        checks++;
        if (!known[word_index(addr)]) begin
            $display("Error: read-back of address %h that was never loaded", addr);
            errors++;
        end else if (actual !== img[word_index(addr)]) begin
            $display("Mismatch test_spm_rd_data addr=%h expected=%h actual=%h",
                     addr, img[word_index(addr)], actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (cpu_en && !cpu_en_q) begin
            run_model();
        end
        if (cpu_en && test_spm_rd_data !== '0) begin
            $display("Error: test port returned non-zero read data while the core was running");
            errors++;
        end
        // test port only counts while the core is halted
        if (!cpu_en && !test_spm_req.as_n) begin
            if (test_spm_req.rw) begin
                img[word_index(test_spm_req.addr)] = test_spm_req.wr_data;
                known[word_index(test_spm_req.addr)] = 1'b1;
            end else begin
                compare_read(test_spm_req.addr, test_spm_rd_data);
            end
        end
        cpu_en_q <= cpu_en;
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_top;

    localparam int NUM_TESTS    = 8;
    localparam int BODY_LEN     = 48;
    localparam int PROG_MAX     = 100;
    localparam int DATA_BASE    = 512;  // word addresses
    localparam int DATA_WORDS   = 64;
    localparam int DUMP_BASE    = 768;
    localparam int DUMP_WORDS   = 32;
    localparam int SPARE_ADDR   = 900;
    localparam int RUN_CYCLES   = 160;
    localparam int DRAIN_CYCLES = 8;
    localparam int TEST_CYCLES  = 4 + PROG_MAX + 2 * (DATA_WORDS + DUMP_WORDS)
                                  + RUN_CYCLES + DRAIN_CYCLES + 16;

    logic              clk;
    logic              arst_n;
    logic              cpu_en;
    cpu_pkg::spm_req_t test_spm_req;
    cpu_pkg::word_t    test_spm_rd_data;
    int                check_count;
    int                error_count;
    logic [31:0]       lfsr_state = 32'hc1bd;
    cpu_pkg::word_t    prog [$];

    pipeline_cpu_top u_pipeline_cpu_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .cpu_en           (cpu_en),
        .test_spm_req     (test_spm_req),
        .test_spm_rd_data (test_spm_rd_data)
    );

    cpu_checker u_cpu_checker (
        .clk              (clk),
        .cpu_en           (cpu_en),
        .test_spm_req     (test_spm_req),
        .test_spm_rd_data (test_spm_rd_data),
        .check_count      (check_count),
        .error_count      (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic cpu_pkg::word_t reg_insn(input logic [5:0] op, input cpu_pkg::gpr_addr_t rd,
                                                input cpu_pkg::gpr_addr_t rs,
                                                input cpu_pkg::gpr_addr_t rt);
        return {op, rd, rs, rt, 11'b0};
    endfunction

    function automatic cpu_pkg::word_t imm_insn(input logic [5:0] op, input cpu_pkg::gpr_addr_t rd,
                                                input cpu_pkg::gpr_addr_t rs, input logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [5:0] pick_alu_op();
        case (lfsr_take(3) % 5)
            0: return `OP_ADD;
            1: return `OP_SUB;
            2: return `OP_AND;
            3: return `OP_OR;
            default: return `OP_XOR;
        endcase
    endfunction

    // byte offset into the data area, misaligned about one time in four
    function automatic logic [15:0] data_offset();
        int word;
        int mis;
        word = int'(lfsr_take(6));
        mis = (lfsr_take(2) == 0) ? int'(lfsr_take(2)) : 0;
        return 16'(DATA_BASE * 4 + word * 4 + mis);
    endfunction

    task automatic build_program();
        int                 kind;
        int                 pos;
        int                 off;
        cpu_pkg::gpr_addr_t rd;
        cpu_pkg::gpr_addr_t rs;
        cpu_pkg::gpr_addr_t rt;
        prog.delete();
        while (prog.size() < BODY_LEN) begin
            kind = int'(lfsr_take(4));
            rd = cpu_pkg::gpr_addr_t'(lfsr_take(3));  // r0..r7 keeps chains dense
            rs = cpu_pkg::gpr_addr_t'(lfsr_take(3));
            rt = cpu_pkg::gpr_addr_t'(lfsr_take(3));
            if (kind < 6) begin
                prog.push_back(reg_insn(pick_alu_op(), rd, rs, rt));
            end else if (kind < 9) begin
                prog.push_back(imm_insn(`OP_ADDI, rd, rs, 16'(lfsr_take(16))));
            end else if (kind < 11) begin
                prog.push_back(imm_insn(`OP_LOAD, rd, '0, data_offset()));
                prog.push_back('0);  // no load-use interlock
            end else if (kind < 13) begin
                prog.push_back(imm_insn(`OP_STORE, rd, '0, data_offset()));
            end else if (kind < 15 && prog.size() + 2 < BODY_LEN) begin
                pos = prog.size();
                off = int'(lfsr_take(2)) + 1;
                if (pos + 1 + off > BODY_LEN) begin
                    off = BODY_LEN - pos - 1;
                end
                prog.push_back(imm_insn(`OP_BEQ, rd, rs, 16'(off)));
                prog.push_back(reg_insn(pick_alu_op(), rt, rs, rd));  // delay slot
            end else begin
                prog.push_back('0);
            end
        end
        for (int r = 1; r < 32; r++) begin
            prog.push_back(imm_insn(`OP_STORE, cpu_pkg::gpr_addr_t'(r), '0,
                                    16'(DUMP_BASE * 4 + r * 4)));
        end
        prog.push_back(imm_insn(`OP_BEQ, '0, '0, 16'hffff));
        prog.push_back('0);
    endtask

    task automatic write_word(input int addr, input cpu_pkg::word_t data);
        @(posedge clk);
        test_spm_req.as_n    <= 1'b0;
        test_spm_req.rw      <= 1'b1;
        test_spm_req.addr    <= cpu_pkg::word_addr_t'(addr);
        test_spm_req.wr_data <= data;
    endtask

    task automatic read_word(input int addr);
        @(posedge clk);
        test_spm_req.as_n <= 1'b0;
        test_spm_req.rw   <= 1'b0;
        test_spm_req.addr <= cpu_pkg::word_addr_t'(addr);
    endtask

    task automatic release_port();
        @(posedge clk);
        test_spm_req.as_n <= 1'b1;
        test_spm_req.rw   <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + 200) @(posedge clk);
        $display("Error: watchdog expired before all tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int checks_before;
        int errors_before;
        arst_n       <= 1'b0;
        cpu_en       <= 1'b0;
        test_spm_req <= '{as_n: 1'b1, rw: 1'b0, addr: '0, wr_data: '0};
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks_before = check_count;
            errors_before = error_count;
            apply_reset();
            build_program();
            for (int i = 0; i < prog.size(); i++) begin
                write_word(i, prog[i]);
            end
            for (int i = 0; i < DATA_WORDS; i++) begin
                write_word(DATA_BASE + i, lfsr_take(32));
            end
            for (int i = 0; i < DUMP_WORDS; i++) begin
                write_word(DUMP_BASE + i, 32'hd0d0_0000 ^ 32'(DUMP_BASE + i));
            end
            write_word(SPARE_ADDR, lfsr_take(32));
            read_word(SPARE_ADDR);
            release_port();
            @(posedge clk);
            cpu_en <= 1'b1;
            // port is cut off from the memory while running
            write_word(SPARE_ADDR, 32'hdead_beef ^ 32'(t));
            read_word(SPARE_ADDR);
            release_port();
            repeat (RUN_CYCLES) @(posedge clk);
            cpu_en <= 1'b0;
            repeat (DRAIN_CYCLES) @(posedge clk);
            for (int i = 0; i < DATA_WORDS; i++) begin
                read_word(DATA_BASE + i);
            end
            for (int i = 0; i < DUMP_WORDS; i++) begin
                read_word(DUMP_BASE + i);
            end
            read_word(SPARE_ADDR);
            release_port();
            @(negedge clk);
            $display("test %0d: %0d instructions, %0d checks, %0d errors", t, prog.size(),
                     check_count - checks_before, error_count - errors_before);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/gpr_file.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/spm.sv
verilog/pipeline_cpu_top.sv
dv/cpu_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_top
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// File: verilog/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`DATA_WIDTH-1:0]      word_t;
    typedef logic [`WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [`GPR_ADDR_WIDTH-1:0]  gpr_addr_t;
    typedef logic [`ALU_OP_WIDTH-1:0]    alu_op_t;

    typedef struct packed {
        logic       valid;
        word_addr_t pc;
        word_t      insn;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        word_t     alu_in_0;
        word_t     alu_in_1;
        logic      is_load;
        logic      is_store;
        word_t     store_data;
        gpr_addr_t dst_addr;
        logic      gpr_we;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_out;   // byte address for loads and stores
        logic      is_load;
        logic      is_store;
        word_t     store_data;
        gpr_addr_t dst_addr;
        logic      gpr_we;
    } ex_mem_t;

    typedef struct packed {
        word_t     wr_data;
        gpr_addr_t dst_addr;
        logic      gpr_we;
    } mem_wb_t;

    // as_n low selects an access, rw high writes
    typedef struct packed {
        logic       as_n;
        logic       rw;
        word_addr_t addr;
        word_t      wr_data;
    } spm_req_t;

endpackage

// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_WIDTH      32
`define WORD_ADDR_WIDTH 30
`define GPR_ADDR_WIDTH  5
`define SPM_DEPTH       1024

// opcodes
`define OPCODE_WIDTH 6
`define OP_NOP   6'h00
`define OP_ADD   6'h01
`define OP_SUB   6'h02
`define OP_AND   6'h03
`define OP_OR    6'h04
`define OP_XOR   6'h05
`define OP_ADDI  6'h06
`define OP_LOAD  6'h07
`define OP_STORE 6'h08
`define OP_BEQ   6'h09

`define ALU_OP_WIDTH 3
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_XOR 3'd4

// instruction fields; rt overlaps imm and is only meaningful for register ops
`define INSN_OP_BITS  31:26
`define INSN_RD_BITS  25:21
`define INSN_RS_BITS  20:16
`define INSN_RT_BITS  15:11
`define INSN_IMM_BITS 15:0
`define IMM_WIDTH     16

`endif

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  cpu_pkg::fetch_t     fetch,
    output cpu_pkg::gpr_addr_t  rd_addr_0,
    output cpu_pkg::gpr_addr_t  rd_addr_1,
    input  cpu_pkg::word_t      rd_data_0,
    input  cpu_pkg::word_t      rd_data_1,
    input  cpu_pkg::id_ex_t     ex_fwd,
    input  cpu_pkg::word_t      alu_out,
    input  cpu_pkg::word_t      fwd_mem_data,
    input  cpu_pkg::ex_mem_t    ex_mem,
    input  cpu_pkg::mem_wb_t    mem_wb,
    output logic                br_taken,
    output cpu_pkg::word_addr_t br_addr,
    output cpu_pkg::id_ex_t     id_ex
);

    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`IMM_WIDTH-1:0]    imm;
    cpu_pkg::word_t           imm_ext;
    cpu_pkg::gpr_addr_t       dst_addr;
    cpu_pkg::alu_op_t         alu_op;
    logic                     is_rtype;
    logic                     is_load;
    logic                     is_store;
    logic                     gpr_we;
    logic                     ex_mem_we;
    cpu_pkg::word_t           op_0;
    cpu_pkg::word_t           op_1;

    assign opcode   = fetch.insn[`INSN_OP_BITS];
    assign imm      = fetch.insn[`INSN_IMM_BITS];
    assign imm_ext  = {{(`DATA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
    assign dst_addr = fetch.insn[`INSN_RD_BITS];

    assign is_rtype = opcode inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR};
    assign is_load  = opcode == `OP_LOAD;
    assign is_store = opcode == `OP_STORE;
    assign gpr_we   = (is_rtype || is_load || opcode == `OP_ADDI) && dst_addr != '0;

    // second read port takes rd for store data and beq
    assign rd_addr_0 = fetch.insn[`INSN_RS_BITS];
    assign rd_addr_1 = is_rtype ? fetch.insn[`INSN_RT_BITS] : dst_addr;

    always_comb begin
        case (opcode)
            `OP_SUB: alu_op = `ALU_SUB;
            `OP_AND: alu_op = `ALU_AND;
            `OP_OR:  alu_op = `ALU_OR;
            `OP_XOR: alu_op = `ALU_XOR;
            default: alu_op = `ALU_ADD;  // add, addi, address calc
        endcase
    end

    // a misaligned load in mem writes nothing, so it must not forward either
    assign ex_mem_we = ex_mem.valid && ex_mem.gpr_we
                       && !(ex_mem.is_load && ex_mem.alu_out[1:0] != 2'b00);

    // youngest in-flight write wins
    function automatic cpu_pkg::word_t fwd(input cpu_pkg::gpr_addr_t addr,
                                           input cpu_pkg::word_t gpr_val);
        if (ex_fwd.valid && ex_fwd.gpr_we && ex_fwd.dst_addr == addr) begin
            return alu_out;
        end else if (ex_mem_we && ex_mem.dst_addr == addr) begin
            return fwd_mem_data;
        end else if (mem_wb.gpr_we && mem_wb.dst_addr == addr) begin
            return mem_wb.wr_data;
        end
        return gpr_val;
    endfunction

    assign op_0 = fwd(rd_addr_0, rd_data_0);
    assign op_1 = fwd(rd_addr_1, rd_data_1);

    // offset counts words from the slot after the branch
    assign br_taken = fetch.valid && opcode == `OP_BEQ && op_0 == op_1;
    assign br_addr  = fetch.pc + cpu_pkg::word_addr_t'(1) + imm_ext[`WORD_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else begin
            id_ex.valid      <= fetch.valid;
            id_ex.alu_op     <= alu_op;
            id_ex.alu_in_0   <= op_0;
            id_ex.alu_in_1   <= is_rtype ? op_1 : imm_ext;
            id_ex.is_load    <= is_load;
            id_ex.is_store   <= is_store;
            id_ex.store_data <= op_1;
            id_ex.dst_addr   <= dst_addr;
            id_ex.gpr_we     <= fetch.valid && gpr_we;
        end
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::id_ex_t   id_ex,
    output cpu_pkg::word_t    alu_out,
    output cpu_pkg::ex_mem_t  ex_mem
);

    // also feeds decode forwarding directly
    always_comb begin
        case (id_ex.alu_op)
            `ALU_ADD: begin
                alu_out = id_ex.alu_in_0 + id_ex.alu_in_1;
            end
            `ALU_SUB: begin
                alu_out = id_ex.alu_in_0 - id_ex.alu_in_1;
            end
            `ALU_AND: begin
                alu_out = id_ex.alu_in_0 & id_ex.alu_in_1;
            end
            `ALU_OR: begin
                alu_out = id_ex.alu_in_0 | id_ex.alu_in_1;
            end
            `ALU_XOR: begin
                alu_out = id_ex.alu_in_0 ^ id_ex.alu_in_1;
            end
            default: begin
                alu_out = '0;  // unused codes
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_out    <= alu_out;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
            ex_mem.store_data <= id_ex.store_data;
            ex_mem.dst_addr   <= id_ex.dst_addr;
            ex_mem.gpr_we     <= id_ex.gpr_we;
        end
    end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cpu_en,
    input  logic                br_taken,
    input  cpu_pkg::word_addr_t br_addr,
    input  cpu_pkg::word_t      insn,
    output cpu_pkg::word_addr_t pc,
    output cpu_pkg::fetch_t     fetch
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (cpu_en) begin
            // redirect lands after the delay slot has been fetched
            if (br_taken) begin
                pc <= br_addr;
            end else begin
                pc <= pc + cpu_pkg::word_addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch <= '0;
        end else begin
            fetch.valid <= cpu_en;  // bubbles while halted
            fetch.pc    <= pc;
            fetch.insn  <= insn;
        end
    end

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module gpr_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::gpr_addr_t rd_addr_0,
    input  cpu_pkg::gpr_addr_t rd_addr_1,
    output cpu_pkg::word_t     rd_data_0,
    output cpu_pkg::word_t     rd_data_1,
    input  cpu_pkg::mem_wb_t   mem_wb
);

    cpu_pkg::word_t regs [2**`GPR_ADDR_WIDTH];

    function automatic cpu_pkg::word_t read_gpr(input cpu_pkg::gpr_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (mem_wb.gpr_we && mem_wb.dst_addr == addr) begin
            return mem_wb.wr_data;  // same-cycle write passes through
        end
        return regs[addr];
    endfunction

    assign rd_data_0 = read_gpr(rd_addr_0);
    assign rd_data_1 = read_gpr(rd_addr_1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**`GPR_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (mem_wb.gpr_we && mem_wb.dst_addr != '0) begin
            regs[mem_wb.dst_addr] <= mem_wb.wr_data;
        end
    end

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::ex_mem_t   ex_mem,
    output cpu_pkg::spm_req_t  spm_req,
    input  cpu_pkg::word_t     spm_rd_data,
    output cpu_pkg::word_t     fwd_mem_data,
    output cpu_pkg::mem_wb_t   mem_wb
);

    logic misaligned;
    logic mem_access;

    // alu_out is a byte address, word accesses only
    assign misaligned = ex_mem.alu_out[1:0] != 2'b00;
    assign mem_access = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store) && !misaligned;

    always_comb begin
        spm_req.as_n    = !mem_access;
        spm_req.rw      = ex_mem.is_store;
        spm_req.addr    = ex_mem.alu_out[`DATA_WIDTH-1:2];
        spm_req.wr_data = ex_mem.store_data;
    end

    // writeback value, also forwarded to decode
    assign fwd_mem_data = ex_mem.is_load ? spm_rd_data : ex_mem.alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.wr_data  <= fwd_mem_data;
            mem_wb.dst_addr <= ex_mem.dst_addr;
            // dropped load leaves its destination untouched
            mem_wb.gpr_we   <= ex_mem.valid && ex_mem.gpr_we
                               && !(ex_mem.is_load && misaligned);
        end
    end

endmodule

// File: verilog/pipeline_cpu_top.sv
`timescale 1ns/1ps

module pipeline_cpu_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_en,
    input  cpu_pkg::spm_req_t test_spm_req,
    output cpu_pkg::word_t    test_spm_rd_data
);

    cpu_pkg::word_addr_t pc;
    cpu_pkg::word_t      insn;
    cpu_pkg::fetch_t     fetch;
    logic                br_taken;
    cpu_pkg::word_addr_t br_addr;
    cpu_pkg::gpr_addr_t  rd_addr_0;
    cpu_pkg::gpr_addr_t  rd_addr_1;
    cpu_pkg::word_t      rd_data_0;
    cpu_pkg::word_t      rd_data_1;
    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::word_t      alu_out;
    cpu_pkg::ex_mem_t    ex_mem;
    cpu_pkg::word_t      fwd_mem_data;
    cpu_pkg::mem_wb_t    mem_wb;
    cpu_pkg::spm_req_t   mem_spm_req;
    cpu_pkg::spm_req_t   port1_req;
    cpu_pkg::word_t      port1_rd_data;

    fetch_stage u_fetch_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_en   (cpu_en),
        .br_taken (br_taken),
        .br_addr  (br_addr),
        .insn     (insn),
        .pc       (pc),
        .fetch    (fetch)
    );

    decode_stage u_decode_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch        (fetch),
        .rd_addr_0    (rd_addr_0),
        .rd_addr_1    (rd_addr_1),
        .rd_data_0    (rd_data_0),
        .rd_data_1    (rd_data_1),
        .ex_fwd       (id_ex),
        .alu_out      (alu_out),
        .fwd_mem_data (fwd_mem_data),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .br_taken     (br_taken),
        .br_addr      (br_addr),
        .id_ex        (id_ex)
    );

    gpr_file u_gpr_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1),
        .mem_wb    (mem_wb)
    );

    execute_stage u_execute_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_ex   (id_ex),
        .alu_out (alu_out),
        .ex_mem  (ex_mem)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_mem       (ex_mem),
        .spm_req      (mem_spm_req),
        .spm_rd_data  (port1_rd_data),
        .fwd_mem_data (fwd_mem_data),
        .mem_wb       (mem_wb)
    );

    spm u_spm (
        .clk           (clk),
        .port0_addr    (pc),
        .port0_rd_data (insn),
        .port1_req     (port1_req),
        .port1_rd_data (port1_rd_data)
    );

    // test port owns the data side while the core is halted
    assign port1_req        = cpu_en ? mem_spm_req : test_spm_req;
    assign test_spm_rd_data = cpu_en ? '0 : port1_rd_data;

endmodule

// File: verilog/spm.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module spm (
    input  logic                clk,
    input  cpu_pkg::word_addr_t port0_addr,
    output cpu_pkg::word_t      port0_rd_data,
    input  cpu_pkg::spm_req_t   port1_req,
    output cpu_pkg::word_t      port1_rd_data
);

    localparam int IDX_WIDTH = $clog2(`SPM_DEPTH);

    cpu_pkg::word_t           mem [`SPM_DEPTH];
    logic [IDX_WIDTH-1:0]     idx_0;
    logic [IDX_WIDTH-1:0]     idx_1;

    // upper address bits ignored, the array wraps
    assign idx_0 = port0_addr[IDX_WIDTH-1:0];
    assign idx_1 = port1_req.addr[IDX_WIDTH-1:0];

    assign port0_rd_data = mem[idx_0];  // instruction side
    assign port1_rd_data = mem[idx_1];

    always_ff @(posedge clk) begin
        if (!port1_req.as_n && port1_req.rw) begin
            mem[idx_1] <= port1_req.wr_data;
        end
    end

endmodule
